//--- alu_core/alu_exec.sv
`timescale 1ns/1ps

module alu_exec
(
	input logic clk,
	input logic reset,
	// queue head
	input logic q_valid,
	input regfile_pkg::opcode_t q_op,
	input logic [regfile_pkg::addr_width-1:0] q_rd,
	input logic [regfile_pkg::addr_width-1:0] q_rs,
	input logic [regfile_pkg::addr_width-1:0] q_rt,
	input logic [regfile_pkg::shamt_width-1:0] q_shamt,
	// operand reads come back combinationally
	input logic [regfile_pkg::data_width-1:0] rs_data,
	input logic [regfile_pkg::data_width-1:0] rt_data,
	input logic wr_gnt,
	output logic q_pop,
	output logic [regfile_pkg::addr_width-1:0] rs_addr,
	output logic [regfile_pkg::addr_width-1:0] rt_addr,
	// write request toward the arbiter
	output logic wr_req,
	output logic [regfile_pkg::addr_width-1:0] wr_addr,
	output logic [regfile_pkg::data_width-1:0] wr_data,
	output logic idle_stage
);

	// stage 2 state and payload
	regfile_pkg::exec_state_t s2_state;
	logic [regfile_pkg::addr_width-1:0] s2_rd;
	logic [regfile_pkg::data_width-1:0] s2_data;

	// stage 1 internals
	logic [regfile_pkg::data_width-1:0] result;
	logic s2_full;
	logic hazard;
	logic back_pressure;

	////////////////////////////////////////////////////////////
	// stage 1: read and compute
	////////////////////////////////////////////////////////////

	// operands straight from the head entry
	assign rs_addr = q_rs;
	assign rt_addr = q_rt;

	always_comb
	begin
		case (q_op)
			regfile_pkg::op_add: result = rs_data + rt_data;
			regfile_pkg::op_sub: result = rs_data - rt_data;
			regfile_pkg::op_and: result = rs_data & rt_data;
			regfile_pkg::op_or: result = rs_data | rt_data;
			regfile_pkg::op_xor: result = rs_data ^ rt_data;
			// signed compare, result is 0 or 1
			regfile_pkg::op_slt:
				result = ($signed(rs_data) < $signed(rt_data)) ? 1 : 0;
			// shifts act on rt only
			regfile_pkg::op_sll: result = rt_data << q_shamt;
			regfile_pkg::op_srl: result = rt_data >> q_shamt;
			default: result = '0;
		endcase
	end

	////////////////////////////////////////////////////////////
	// stall rules
	////////////////////////////////////////////////////////////

	assign s2_full = (s2_state == regfile_pkg::st_wait_grant);

	// raw on the pending destination
	// holds even in the grant cycle, the write lands only at the edge
	assign hazard = s2_full & ((s2_rd == q_rs) | (s2_rd == q_rt));

	// stage 2 busy and not draining this cycle
	assign back_pressure = s2_full & ~wr_gnt;

	assign q_pop = q_valid & ~hazard & ~back_pressure;

	////////////////////////////////////////////////////////////
	// stage 2: hold until granted
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
			s2_state <= regfile_pkg::st_empty;
		else if (q_pop)
			s2_state <= regfile_pkg::st_wait_grant;
		else if (wr_gnt)
			s2_state <= regfile_pkg::st_empty;
	end

	// payload only loads on a pop
	always_ff @(posedge clk)
	begin
		if (q_pop)
		begin
			s2_rd <= q_rd;
			s2_data <= result;
		end
	end

	// request stays up with steady data until the grant
	assign wr_req = s2_full;
	assign wr_addr = s2_rd;
	assign wr_data = s2_data;
	assign idle_stage = (s2_state == regfile_pkg::st_empty);

endmodule

//--- common/regfile_pkg.sv
package regfile_pkg;

	////////////////////////////////////////////////////////////
	// sizes
	////////////////////////////////////////////////////////////

	// register word width
	localparam int data_width = 32;
	// register index width
	localparam int addr_width = 5;
	// entries in the register array
	localparam int num_regs = 32;
	// shift amount field
	localparam int shamt_width = 5;

	// instruction queue depth
	// the host starts with this many credits
	localparam int queue_depth = 4;
	// wide enough to hold 0..queue_depth
	localparam int credit_width = 3;

	////////////////////////////////////////////////////////////
	// types
	////////////////////////////////////////////////////////////

	// r-type operations
	// slt compares signed, shifts move rt by shamt
	typedef enum logic [2:0]
	{
		op_add,
		op_sub,
		op_and,
		op_or,
		op_xor,
		op_slt,
		op_sll,
		op_srl
	} opcode_t;

	// write stage of the execute unit
	typedef enum logic
	{
		st_empty,
		st_wait_grant
	} exec_state_t;

	// packed queue entry, opcode then rd, rs, rt, shamt
	localparam int instr_width = $bits(opcode_t) + 3 * addr_width + shamt_width;

endpackage

//--- hw/instr_queue.sv
`timescale 1ns/1ps

module instr_queue
(
	input logic clk,
	input logic reset,
	// host side, never refused since credits guarantee room
	input logic push,
	input regfile_pkg::opcode_t push_op,
	input logic [regfile_pkg::addr_width-1:0] push_rd,
	input logic [regfile_pkg::addr_width-1:0] push_rs,
	input logic [regfile_pkg::addr_width-1:0] push_rt,
	input logic [regfile_pkg::shamt_width-1:0] push_shamt,
	// execute unit side
	input logic pop,
	output logic q_valid,
	output regfile_pkg::opcode_t q_op,
	output logic [regfile_pkg::addr_width-1:0] q_rd,
	output logic [regfile_pkg::addr_width-1:0] q_rs,
	output logic [regfile_pkg::addr_width-1:0] q_rt,
	output logic [regfile_pkg::shamt_width-1:0] q_shamt,
	// one pulse per drained entry
	output logic credit_return
);

	// entry storage, no reset needed
	logic [regfile_pkg::instr_width-1:0] mem [regfile_pkg::queue_depth];
	logic [regfile_pkg::instr_width-1:0] head_entry;
	logic [$bits(regfile_pkg::opcode_t)-1:0] head_op_bits;

	// pointers wrap on their own, depth is a power of two
	logic [$clog2(regfile_pkg::queue_depth)-1:0] wr_ptr;
	logic [$clog2(regfile_pkg::queue_depth)-1:0] rd_ptr;
	// occupancy 0..queue_depth
	logic [regfile_pkg::credit_width-1:0] count;

	////////////////////////////////////////////////////////////
	// storage write
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (push)
		begin
			mem[wr_ptr] <= {push_op, push_rd, push_rs, push_rt, push_shamt};
		end
	end

	////////////////////////////////////////////////////////////
	// pointers, count, credit pulse
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credit_return <= 1'b0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			// push and pop together leave count alone
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			// registered, one cycle per pop
			credit_return <= pop;
		end
	end

	////////////////////////////////////////////////////////////
	// head view
	////////////////////////////////////////////////////////////

	// an entry pushed on an empty queue is visible after one edge
	assign q_valid = (count != '0);
	assign head_entry = mem[rd_ptr];
	assign {head_op_bits, q_rd, q_rs, q_rt, q_shamt} = head_entry;
	assign q_op = regfile_pkg::opcode_t'(head_op_bits);

endmodule

//--- hw/regfile_subsystem.sv
`timescale 1ns/1ps

module regfile_subsystem
(
	input logic clk,
	input logic reset,
	// instruction path, credit based
	input logic instr_valid,
	input regfile_pkg::opcode_t instr_op,
	input logic [regfile_pkg::addr_width-1:0] instr_rd,
	input logic [regfile_pkg::addr_width-1:0] instr_rs,
	input logic [regfile_pkg::addr_width-1:0] instr_rt,
	input logic [regfile_pkg::shamt_width-1:0] instr_shamt,
	output logic credit_return,
	// host load port
	input logic host_wr_req,
	input logic [regfile_pkg::addr_width-1:0] host_wr_addr,
	input logic [regfile_pkg::data_width-1:0] host_wr_data,
	output logic host_wr_ready,
	// host read port
	input logic [regfile_pkg::addr_width-1:0] host_rd_addr,
	output logic [regfile_pkg::data_width-1:0] host_rd_data,
	// nothing queued and nothing waiting to write
	output logic idle
);

	// queue to execute unit
	logic q_valid;
	logic q_pop;
	regfile_pkg::opcode_t q_op;
	logic [regfile_pkg::addr_width-1:0] q_rd;
	logic [regfile_pkg::addr_width-1:0] q_rs;
	logic [regfile_pkg::addr_width-1:0] q_rt;
	logic [regfile_pkg::shamt_width-1:0] q_shamt;

	// operand reads
	logic [regfile_pkg::addr_width-1:0] rs_addr;
	logic [regfile_pkg::addr_width-1:0] rt_addr;
	logic [regfile_pkg::data_width-1:0] rs_data;
	logic [regfile_pkg::data_width-1:0] rt_data;

	// alu write request and arbiter output
	logic alu_wr_req;
	logic alu_wr_gnt;
	logic host_wr_gnt;
	logic [regfile_pkg::addr_width-1:0] alu_wr_addr;
	logic [regfile_pkg::data_width-1:0] alu_wr_data;
	logic wr_en;
	logic [regfile_pkg::addr_width-1:0] wr_addr;
	logic [regfile_pkg::data_width-1:0] wr_data;
	logic idle_stage;

	////////////////////////////////////////////////////////////
	// blocks
	////////////////////////////////////////////////////////////

	instr_queue queue_i
	(
		.clk(clk),
		.reset(reset),
		.push(instr_valid),
		.push_op(instr_op),
		.push_rd(instr_rd),
		.push_rs(instr_rs),
		.push_rt(instr_rt),
		.push_shamt(instr_shamt),
		.pop(q_pop),
		.q_valid(q_valid),
		.q_op(q_op),
		.q_rd(q_rd),
		.q_rs(q_rs),
		.q_rt(q_rt),
		.q_shamt(q_shamt),
		.credit_return(credit_return)
	);

	alu_exec exec_i
	(
		.clk(clk),
		.reset(reset),
		.q_valid(q_valid),
		.q_op(q_op),
		.q_rd(q_rd),
		.q_rs(q_rs),
		.q_rt(q_rt),
		.q_shamt(q_shamt),
		.rs_data(rs_data),
		.rt_data(rt_data),
		.wr_gnt(alu_wr_gnt),
		.q_pop(q_pop),
		.rs_addr(rs_addr),
		.rt_addr(rt_addr),
		.wr_req(alu_wr_req),
		.wr_addr(alu_wr_addr),
		.wr_data(alu_wr_data),
		.idle_stage(idle_stage)
	);

	// alu and host share the single write port
	write_arbiter arb_i
	(
		.clk(clk),
		.reset(reset),
		.alu_req(alu_wr_req),
		.alu_addr(alu_wr_addr),
		.alu_data(alu_wr_data),
		.host_req(host_wr_req),
		.host_addr(host_wr_addr),
		.host_data(host_wr_data),
		.alu_gnt(alu_wr_gnt),
		.host_gnt(host_wr_gnt),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data)
	);

	register_file rf_i
	(
		.clk(clk),
		.reset(reset),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.rd_addr_a(rs_addr),
		.rd_addr_b(rt_addr),
		.rd_addr_c(host_rd_addr),
		.rd_data_a(rs_data),
		.rd_data_b(rt_data),
		.rd_data_c(host_rd_data)
	);

	// host sees its grant as ready
	assign host_wr_ready = host_wr_gnt;
	// empty queue and empty write stage
	assign idle = ~q_valid & idle_stage;

endmodule

//--- hw/register_file.sv
`timescale 1ns/1ps

module register_file
(
	input logic clk,
	input logic reset,
	// single write port, driven by the arbiter
	input logic wr_en,
	input logic [regfile_pkg::addr_width-1:0] wr_addr,
	input logic [regfile_pkg::data_width-1:0] wr_data,
	// a and b feed the execute unit, c is the host port
	input logic [regfile_pkg::addr_width-1:0] rd_addr_a,
	input logic [regfile_pkg::addr_width-1:0] rd_addr_b,
	input logic [regfile_pkg::addr_width-1:0] rd_addr_c,
	output logic [regfile_pkg::data_width-1:0] rd_data_a,
	output logic [regfile_pkg::data_width-1:0] rd_data_b,
	output logic [regfile_pkg::data_width-1:0] rd_data_c
);

	// storage
	logic [regfile_pkg::data_width-1:0] regs [regfile_pkg::num_regs];

	////////////////////////////////////////////////////////////
	// write side
	////////////////////////////////////////////////////////////

	// rising edge write, reset clears every entry
	// r0 is an ordinary register here, not hardwired to zero
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < regfile_pkg::num_regs; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (wr_en)
		begin
			regs[wr_addr] <= wr_data;
		end
	end

	////////////////////////////////////////////////////////////
	// read side
	////////////////////////////////////////////////////////////

	// combinational reads
	// a write shows here the cycle after its grant
	assign rd_data_a = regs[rd_addr_a];
	assign rd_data_b = regs[rd_addr_b];
	assign rd_data_c = regs[rd_addr_c];

endmodule

//--- hw/write_arbiter.sv
`timescale 1ns/1ps

module write_arbiter
(
	input logic clk,
	input logic reset,
	// alu requester
	input logic alu_req,
	input logic [regfile_pkg::addr_width-1:0] alu_addr,
	input logic [regfile_pkg::data_width-1:0] alu_data,
	// host requester
	input logic host_req,
	input logic [regfile_pkg::addr_width-1:0] host_addr,
	input logic [regfile_pkg::data_width-1:0] host_data,
	// grants, at most one high
	output logic alu_gnt,
	output logic host_gnt,
	// to the register file write port
	output logic wr_en,
	output logic [regfile_pkg::addr_width-1:0] wr_addr,
	output logic [regfile_pkg::data_width-1:0] wr_data
);

	// high when the alu took the most recent grant
	logic last_alu;

	////////////////////////////////////////////////////////////
	// round robin pick
	////////////////////////////////////////////////////////////

	// uncontended: whoever asks gets it
	// contended: the side not served last wins
	assign alu_gnt = alu_req & (~host_req | ~last_alu);
	assign host_gnt = host_req & ~alu_gnt;

	// remember the winner for the next contended cycle
	always_ff @(posedge clk)
	begin
		if (reset)
			last_alu <= 1'b0;
		else if (alu_gnt)
			last_alu <= 1'b1;
		else if (host_gnt)
			last_alu <= 1'b0;
	end

	// steer the granted side onto the write port
	assign wr_en = alu_gnt | host_gnt;
	assign wr_addr = alu_gnt ? alu_addr : host_addr;
	assign wr_data = alu_gnt ? alu_data : host_data;

endmodule

//--- run_sim.sh
#!/bin/sh
# build the testbench with verilator, run it, judge the log

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module regfile_tb -f tb.f -o regfile_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/regfile_sim > "$log" 2>&1
status=$?
cat "$log"

if grep -q "Test FAILED" "$log"; then
	echo "simulation reported a failure"
	exit 1
fi

if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

echo "simulation passed"
exit 0

//--- tb.f
common/regfile_pkg.sv
hw/register_file.sv
hw/instr_queue.sv
hw/write_arbiter.sv
alu_core/alu_exec.sv
hw/regfile_subsystem.sv
verification/tb_clock_gen.sv
verification/regfile_tb.sv

//--- verification/regfile_tb.sv
`timescale 1ns/1ps

module regfile_tb;

	// wait limits in clock cycles
	localparam int reset_timeout = 100;
	localparam int credit_timeout = 500;
	localparam int grant_timeout = 500;
	localparam int idle_timeout = 2000;
	localparam int done_timeout = 5000;
	localparam int request_timeout = 50000;

	logic clk;
	logic reset;

	// dut inputs
	logic instr_valid;
	regfile_pkg::opcode_t instr_op;
	logic [regfile_pkg::addr_width-1:0] instr_rd;
	logic [regfile_pkg::addr_width-1:0] instr_rs;
	logic [regfile_pkg::addr_width-1:0] instr_rt;
	logic [regfile_pkg::shamt_width-1:0] instr_shamt;
	logic host_wr_req;
	logic [regfile_pkg::addr_width-1:0] host_wr_addr;
	logic [regfile_pkg::data_width-1:0] host_wr_data;
	logic [regfile_pkg::addr_width-1:0] host_rd_addr;

	// dut outputs
	logic credit_return;
	logic host_wr_ready;
	logic [regfile_pkg::data_width-1:0] host_rd_data;
	logic idle;

	// host credit state and counters
	int credits = regfile_pkg::queue_depth;
	int sent = 0;
	int returned = 0;

	// sequential model of the register array
	logic [regfile_pkg::data_width-1:0] shadow [regfile_pkg::num_regs];

	// handshake with the comparing process
	logic check_req = 1'b0;
	logic check_done = 1'b0;
	logic all_done = 1'b0;

	tb_clock_gen clock_i
	(
		.clk(clk),
		.reset(reset)
	);

	regfile_subsystem dut_i
	(
		.clk(clk),
		.reset(reset),
		.instr_valid(instr_valid),
		.instr_op(instr_op),
		.instr_rd(instr_rd),
		.instr_rs(instr_rs),
		.instr_rt(instr_rt),
		.instr_shamt(instr_shamt),
		.credit_return(credit_return),
		.host_wr_req(host_wr_req),
		.host_wr_addr(host_wr_addr),
		.host_wr_data(host_wr_data),
		.host_wr_ready(host_wr_ready),
		.host_rd_addr(host_rd_addr),
		.host_rd_data(host_rd_data),
		.idle(idle)
	);

	////////////////////////////////////////////////////////////
	// failure reporting
	////////////////////////////////////////////////////////////

	task automatic stop_on_mismatch(input string what);
		$display("error at time %0t: %s", $time, what);
		$display("Test FAILED");
		$fatal(1, "check failed");
	endtask

	task automatic give_up_waiting(input string what);
		$display("timed out at %0t while waiting for %s", $time, what);
		$display("Test FAILED");
		$fatal(1, "wait timed out");
	endtask

	////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////

	// r-type result from the operation rules
	function automatic logic [31:0] ref_result(input regfile_pkg::opcode_t op,
		input logic [31:0] a, input logic [31:0] b, input logic [4:0] sh);
		case (op)
			regfile_pkg::op_add: return a + b;
			regfile_pkg::op_sub: return a - b;
			regfile_pkg::op_and: return a & b;
			regfile_pkg::op_or: return a | b;
			regfile_pkg::op_xor: return a ^ b;
			// signed less-than gives 0 or 1
			regfile_pkg::op_slt: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			// shifts only use rt
			regfile_pkg::op_sll: return b << sh;
			regfile_pkg::op_srl: return b >> sh;
			default: return 32'd0;
		endcase
	endfunction

	function automatic logic [4:0] pick_reg(input int lo, input int hi);
		return 5'($urandom_range(hi, lo));
	endfunction

	////////////////////////////////////////////////////////////
	// host side tasks called 2 ns after a rising edge
	////////////////////////////////////////////////////////////

	// one queue push that spends a credit
	task automatic send_instr(input regfile_pkg::opcode_t op, input logic [4:0] rd,
		input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] sh);
		int waited;
		waited = 0;
		while (credits == 0)
		begin
			instr_valid = 1'b0;
			@(posedge clk);
			#2;
			waited++;
			if (waited > credit_timeout)
				give_up_waiting("a returned credit");
		end
		// sequential semantics
		// model updates at issue
		shadow[rd] = ref_result(op, shadow[rs], shadow[rt], sh);
		instr_valid = 1'b1;
		instr_op = op;
		instr_rd = rd;
		instr_rs = rs;
		instr_rt = rt;
		instr_shamt = sh;
		credits--;
		sent++;
		@(posedge clk);
		#2;
		instr_valid = 1'b0;
	endtask

	// load one register and hold the request until ready
	task automatic host_write(input logic [4:0] addr, input logic [31:0] data);
		int waited;
		logic granted;
		waited = 0;
		granted = 1'b0;
		host_wr_req = 1'b1;
		host_wr_addr = addr;
		host_wr_data = data;
		while (!granted)
		begin
			// ready sampled mid cycle
			// write lands at the next edge
			@(negedge clk);
			if (host_wr_ready)
				granted = 1'b1;
			else
			begin
				waited++;
				if (waited > grant_timeout)
					give_up_waiting("host write grant");
			end
			@(posedge clk);
			#2;
		end
		host_wr_req = 1'b0;
		shadow[addr] = data;
	endtask

	// hand a full readback to the comparing process
	task automatic run_check();
		int waited;
		waited = 0;
		check_done = 1'b0;
		check_req = 1'b1;
		while (!check_done)
		begin
			@(posedge clk);
			#2;
			waited++;
			if (waited > done_timeout)
				give_up_waiting("register readback to finish");
		end
	endtask

	////////////////////////////////////////////////////////////
	// credit counting
	////////////////////////////////////////////////////////////

	always @(negedge clk)
	begin
		if (!reset && credit_return)
		begin
			credits++;
			returned++;
			assert (credits <= regfile_pkg::queue_depth)
			else stop_on_mismatch("more credits returned than instructions sent");
		end
	end

	////////////////////////////////////////////////////////////
	// comparing process
	////////////////////////////////////////////////////////////

	initial
	begin : compare_regs
		int waited;
		int r;
		logic [31:0] got;
		while (!all_done)
		begin
			waited = 0;
			while (!check_req && !all_done)
			begin
				@(negedge clk);
				waited++;
				if (waited > request_timeout)
					give_up_waiting("a register check request");
			end
			if (check_req)
			begin
				// let queued and pending writes drain
				waited = 0;
				while (!idle)
				begin
					@(negedge clk);
					waited++;
					if (waited > idle_timeout)
						give_up_waiting("idle");
				end
				for (r = 0; r < regfile_pkg::num_regs; r++)
				begin
					@(posedge clk);
					#2;
					host_rd_addr = 5'(r);
					@(negedge clk);
					got = host_rd_data;
					assert (got == shadow[r])
					else
					begin
						$display("error at time %0t: r%0d read %h, expected %h",
							$time, r, got, shadow[r]);
						$display("Test FAILED");
						$fatal(1, "register mismatch");
					end
				end
				check_req = 1'b0;
				check_done = 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////

	initial
	begin : stimulus
		int waited;
		int k;
		int c;
		logic [4:0] rd;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] prev_rd;
		instr_valid = 1'b0;
		instr_op = regfile_pkg::op_add;
		instr_rd = '0;
		instr_rs = '0;
		instr_rt = '0;
		instr_shamt = '0;
		host_wr_req = 1'b0;
		host_wr_addr = '0;
		host_wr_data = '0;
		host_rd_addr = '0;
		for (k = 0; k < regfile_pkg::num_regs; k++)
			shadow[k] = '0;
		void'($urandom(97));

		waited = 0;
		while (reset !== 1'b0)
		begin
			@(posedge clk);
			waited++;
			if (waited > reset_timeout)
				give_up_waiting("reset release");
		end
		@(posedge clk);
		#2;

		// after reset the outputs are quiet and every register is zero
		@(negedge clk);
		assert (idle && !credit_return && !host_wr_ready)
		else stop_on_mismatch("outputs not in their reset state");
		@(posedge clk);
		#2;
		run_check();

		// host loads every register
		for (k = 0; k < regfile_pkg::num_regs; k++)
			host_write(5'(k), $urandom);
		run_check();

		// one of each opcode
		for (k = 0; k < 8; k++)
		begin
			send_instr(regfile_pkg::opcode_t'(k), pick_reg(0, 31), pick_reg(0, 31),
				pick_reg(0, 31), pick_reg(0, 31));
			run_check();
		end

		// dependent chains back to back through the hazard stall
		for (c = 0; c < 3; c++)
		begin
			prev_rd = pick_reg(0, 31);
			for (k = 0; k < 6; k++)
			begin
				rd = pick_reg(0, 31);
				rs = (k % 2 == 0) ? prev_rd : pick_reg(0, 31);
				rt = (k % 2 == 1) ? prev_rd : pick_reg(0, 31);
				send_instr(regfile_pkg::opcode_t'($urandom_range(7, 0)), rd, rs, rt,
					pick_reg(0, 31));
				prev_rd = rd;
			end
		end
		run_check();

		// drain the credits and keep going on returned ones
		waited = 0;
		while (credits > 0)
		begin
			send_instr(regfile_pkg::opcode_t'($urandom_range(7, 0)), pick_reg(0, 31),
				pick_reg(0, 31), pick_reg(0, 31), pick_reg(0, 31));
			waited++;
			if (waited > credit_timeout)
				give_up_waiting("the host credits to run out");
		end
		for (k = 0; k < 6; k++)
		begin
			send_instr(regfile_pkg::opcode_t'($urandom_range(7, 0)), pick_reg(0, 31),
				pick_reg(0, 31), pick_reg(0, 31), pick_reg(0, 31));
		end
		run_check();
		assert (returned == sent && credits == regfile_pkg::queue_depth)
		else stop_on_mismatch("credit returns do not match instructions sent");

		// alu on r0..r15 and host on r16..r31 at the same time
		fork
			begin : alu_stream
				int i;
				for (i = 0; i < 8; i++)
					send_instr(regfile_pkg::opcode_t'($urandom_range(7, 0)),
						pick_reg(0, 15), pick_reg(0, 15), pick_reg(0, 15), pick_reg(0, 31));
			end
			begin : host_stream
				int j;
				for (j = 0; j < 12; j++)
					host_write(pick_reg(16, 31), $urandom);
			end
		join
		run_check();
		assert (returned == sent)
		else stop_on_mismatch("credit returns do not match instructions sent");

		all_done = 1'b1;
		$display("Test OK");
		$finish;
	end

endmodule

//--- verification/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen
(
	output logic clk,
	output logic reset
);

	// 40 ns period
	localparam int half_period = 20;
	// reset held over this many rising edges
	localparam int reset_cycles = 8;

	initial
	begin
		clk = 1'b0;
		forever
			#(half_period) clk = ~clk;
	end

	// release shortly after an edge, like the rest of the stimulus
	initial
	begin
		reset = 1'b1;
		repeat (reset_cycles) @(posedge clk);
		#2;
		reset = 1'b0;
	end

endmodule
